/* compile.f */
+incdir+logic
logic/axi_pkg.sv
logic/icache_pkg.sv
logic/icache_ram.sv
logic/icache_tags.sv
logic/icache_data.sv
logic/icache_plru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
dv/icache_tb.sv

/* dv/icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_tb;

    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_ENTRIES = NUM_DIRECTED + NUM_RANDOM;
    // a miss with the longest arready stall takes about 16 cycles
    localparam int CYCLES_PER_ENTRY = 30;
    localparam int WATCHDOG_NS = (NUM_ENTRIES * CYCLES_PER_ENTRY + 20) * 10;
    localparam logic [31:0] MEM_KEY = 32'hc0de_5a5a;
    localparam int KIND_MISS = 0;
    localparam int KIND_HIT = 1;
    localparam int KIND_MODEL = 2;

    typedef struct {
        logic [31:0] addr;
        logic        cacheable;
        int          kind;
    } entry_t;

    logic                  clk;
    logic                  rst;
    logic                  req;
    icache_pkg::addr_t     addr;
    logic                  cacheable;
    logic                  ready;
    logic                  data_ok;
    icache_pkg::word_t     rdata;
    logic                  arvalid;
    logic                  arready;
    icache_pkg::addr_t     araddr;
    axi_pkg::len_t         arlen;
    axi_pkg::burst_t       arburst;
    logic                  rvalid;
    icache_pkg::word_t     rdata_bus;
    logic                  rlast;

    logic [31:0]     lfsr_state = 32'h7332_a58c;
    entry_t          stim [NUM_ENTRIES];
    int              errors = 0;
    int              passed = 0;
    int              failed = 0;
    int              ar_count = 0;
    logic [31:0]     ar_addr;
    axi_pkg::len_t   ar_len;
    axi_pkg::burst_t ar_burst;

    // reference state of tags and tree bits
    logic [19:0] mtag [`ICACHE_SETS][`ICACHE_WAYS];
    logic        mvalid [`ICACHE_SETS][`ICACHE_WAYS];
    logic        mroot [`ICACHE_SETS];
    logic        mleaf0 [`ICACHE_SETS];
    logic        mleaf1 [`ICACHE_SETS];

    icache_top UUT (
        .clk(clk),
        .rst(rst),
        .req(req),
        .addr(addr),
        .cacheable(cacheable),
        .ready(ready),
        .data_ok(data_ok),
        .rdata(rdata),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .arlen(arlen),
        .arburst(arburst),
        .rvalid(rvalid),
        .rdata_bus(rdata_bus),
        .rlast(rlast)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // memory content is the word address scrambled by a key
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return {2'b00, byte_addr[31:2]} ^ MEM_KEY;
    endfunction

    function automatic int pick_victim(input int s);
        if (!mroot[s]) begin
            return mleaf0[s] ? 1 : 0;
        end
        return mleaf1[s] ? 3 : 2;
    endfunction

    function automatic void mark_way(input int s, input int w);
        mroot[s] = (w < 2);
        if (w < 2) begin
            mleaf0[s] = (w == 0);
        end else begin
            mleaf1[s] = (w == 2);
        end
    endfunction

    // returns 1 when no bus read is expected
    function automatic logic predict_access(input logic [31:0] a, input logic c);
        int          s;
        int          hit_way;
        int          v;
        logic [19:0] t;
        s = int'(a[11:5]);
        t = a[31:12];
        hit_way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (mvalid[s][w] && mtag[s][w] == t) begin
                hit_way = w;
            end
        end
        if (!c) begin
            return 1'b0;
        end
        if (hit_way >= 0) begin
            mark_way(s, hit_way);
            return 1'b1;
        end
        v = pick_victim(s);
        mtag[s][v] = t;
        mvalid[s][v] = 1'b1;
        mark_way(s, v);
        return 1'b0;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    task automatic put_entry(input int idx, input logic [31:0] a, input logic c, input int k);
        stim[idx].addr = a;
        stim[idx].cacheable = c;
        stim[idx].kind = k;
    endtask

    task automatic fill_table();
        logic [31:0] t;
        logic [31:0] s;
        logic [31:0] o;
        logic [31:0] u;
        put_entry(0, 32'h0000_1024, 1'b1, KIND_MISS);
        put_entry(1, 32'h0000_1038, 1'b1, KIND_HIT);
        put_entry(2, 32'h0000_1020, 1'b1, KIND_HIT);
        put_entry(3, 32'h0000_2044, 1'b0, KIND_MISS);
        put_entry(4, 32'h0000_2044, 1'b0, KIND_MISS);
        put_entry(5, 32'h0000_2040, 1'b1, KIND_MISS);
        put_entry(6, 32'h0000_2044, 1'b1, KIND_HIT);
        // five tags through set 3
        put_entry(7, 32'h0001_0060, 1'b1, KIND_MISS);
        put_entry(8, 32'h0002_0064, 1'b1, KIND_MISS);
        put_entry(9, 32'h0003_0068, 1'b1, KIND_MISS);
        put_entry(10, 32'h0004_006c, 1'b1, KIND_MISS);
        put_entry(11, 32'h0001_0070, 1'b1, KIND_HIT);
        put_entry(12, 32'h0002_007c, 1'b1, KIND_HIT);
        put_entry(13, 32'h0005_0060, 1'b1, KIND_MISS);
        put_entry(14, 32'h0001_0064, 1'b1, KIND_HIT);
        put_entry(15, 32'h0002_0060, 1'b1, KIND_HIT);
        put_entry(16, 32'h0004_0060, 1'b1, KIND_HIT);
        put_entry(17, 32'h0005_007c, 1'b1, KIND_HIT);
        put_entry(18, 32'h0003_0068, 1'b1, KIND_MISS);
        put_entry(19, 32'h0002_0068, 1'b1, KIND_MISS);
        // eight tags over sets 8 to 11, a quarter uncached
        for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
            t = rand_bits(3);
            s = rand_bits(2);
            o = rand_bits(3);
            u = rand_bits(2);
            put_entry(i, {17'd0, t[2:0], 5'b00010, s[1:0], o[2:0], 2'b00},
                      u[1:0] != 2'b00, KIND_MODEL);
        end
    endtask

    task automatic run_entry(input int idx);
        logic [31:0] a;
        logic        c;
        logic        want_hit;
        int          cycles;
        int          ar_before;
        int          err_before;
        a = stim[idx].addr;
        c = stim[idx].cacheable;
        err_before = errors;
        want_hit = predict_access(a, c);
        if (stim[idx].kind != KIND_MODEL && want_hit != (stim[idx].kind == KIND_HIT)) begin
            report_error($sformatf("entry %0d table expectation differs from model", idx));
        end
        @(negedge clk);
        if (!ready || data_ok) begin
            report_error($sformatf("entry %0d cache not idle before request", idx));
        end
        req = 1'b1;
        addr = a;
        cacheable = c;
        ar_before = ar_count;
        @(negedge clk);
        req = 1'b0;
        cycles = 1;
        while (!data_ok) begin
            @(negedge clk);
            cycles++;
        end
        if (want_hit) begin
            if (cycles != 1) begin
                report_error($sformatf("entry %0d hit latency %0d cycles", idx, cycles));
            end
            if (ar_count != ar_before) begin
                report_error($sformatf("entry %0d expected hit but saw a bus read", idx));
            end
        end else begin
            if (ar_count != ar_before + 1) begin
                report_error($sformatf("entry %0d expected one bus read, saw %0d",
                                       idx, ar_count - ar_before));
            end
            if (c && (ar_addr != {a[31:5], 5'b0} || ar_len != 8'd7 ||
                      ar_burst != axi_pkg::INCR)) begin
                report_error($sformatf("entry %0d refill read %h len %0d burst %0d",
                                       idx, ar_addr, ar_len, ar_burst));
            end
            if (!c && (ar_addr != a || ar_len != 8'd0 || ar_burst != axi_pkg::FIXED)) begin
                report_error($sformatf("entry %0d uncached read %h len %0d burst %0d",
                                       idx, ar_addr, ar_len, ar_burst));
            end
        end
        if (rdata !== mem_word(a)) begin
            report_error($sformatf("entry %0d rdata %h, want %h", idx, rdata, mem_word(a)));
        end
        $display("test %0d addr %h %s %s: %s", idx, a, c ? "cached" : "uncached",
                 want_hit ? "hit" : "miss", errors == err_before ? "ok" : "bad");
        if (errors == err_before) begin
            passed++;
        end else begin
            failed++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // AXI read slave with a random arready stall
    initial begin : memory_model
        int          wait_cycles;
        int          beats;
        logic [31:0] beat_addr;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata_bus = '0;
        rlast = 1'b0;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                wait_cycles = int'(rand_bits(2));
                repeat (wait_cycles) @(negedge clk);
                ar_addr = araddr;
                ar_len = arlen;
                ar_burst = arburst;
                ar_count++;
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                beats = int'(ar_len) + 1;
                for (int i = 0; i < beats; i++) begin
                    beat_addr = (ar_burst == axi_pkg::INCR) ? ar_addr + 32'(i * 4) : ar_addr;
                    rvalid = 1'b1;
                    rdata_bus = mem_word(beat_addr);
                    rlast = (i == beats - 1);
                    @(negedge clk);
                end
                rvalid = 1'b0;
                rdata_bus = '0;
                rlast = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run timed out before all table entries finished");
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        rst = 1'b1;
        req = 1'b0;
        addr = '0;
        cacheable = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            mroot[s] = 1'b0;
            mleaf0[s] = 1'b0;
            mleaf1[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                mtag[s][w] = '0;
                mvalid[s][w] = 1'b0;
            end
        end
        fill_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!ready || arvalid || data_ok) begin
            report_error("outputs wrong after reset");
            failed++;
        end else begin
            passed++;
        end
        $display("test reset: %s", errors == 0 ? "ok" : "bad");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // beats minus one
    typedef logic [7:0] len_t;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } burst_t;

endpackage

`default_nettype wire

/* logic/icache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req,
    input  wire icache_pkg::addr_t     addr,
    input  wire                        cacheable,
    output logic                       ready,
    output logic                       data_ok,
    output icache_pkg::word_t          rdata,
    output icache_pkg::addr_t          lookup_addr,
    input  wire icache_pkg::way_mask_t hit_mask,
    input  wire icache_pkg::word_t     hit_word,
    output logic                       refill_we,
    output icache_pkg::offset_t        refill_offset,
    output icache_pkg::word_t          refill_word,
    output logic                       tag_we,
    output logic                       touch,
    output logic                       arvalid,
    input  wire                        arready,
    output icache_pkg::addr_t          araddr,
    output axi_pkg::len_t              arlen,
    output axi_pkg::burst_t            arburst,
    input  wire                        rvalid,
    input  wire icache_pkg::word_t     rdata_bus,
    input  wire                        rlast
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_ADDR,
        ST_DATA,
        ST_UPDATE
    } state_t;

    state_t              state;
    icache_pkg::addr_t   addr_r;
    logic                cacheable_r;
    icache_pkg::offset_t beat;
    icache_pkg::word_t   word_r;
    logic                hit;

    assign hit = |hit_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            cacheable_r <= 1'b0;
            beat        <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        cacheable_r <= cacheable;
                        beat        <= '0;
                        state       <= cacheable ? ST_LOOKUP : ST_ADDR;
                    end
                end
                ST_LOOKUP: begin
                    state <= hit ? ST_IDLE : ST_ADDR;
                end
                ST_ADDR: begin
                    if (arready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        // uncached reads are a single beat
                        if (rlast || !cacheable_r) begin
                            state <= ST_UPDATE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_r <= addr;
        end
        // keep the requested word as it streams past
        if (state == ST_DATA && rvalid &&
            (!cacheable_r || beat == icache_pkg::offset_of(addr_r))) begin
            word_r <= rdata_bus;
        end
    end

    assign ready       = state == ST_IDLE;
    assign lookup_addr = (state == ST_IDLE) ? addr : addr_r;

    assign data_ok = (state == ST_LOOKUP && hit) || state == ST_UPDATE;
    assign rdata   = (state == ST_LOOKUP) ? hit_word : word_r;

    assign refill_we     = state == ST_DATA && rvalid && cacheable_r;
    assign refill_offset = beat;
    assign refill_word   = rdata_bus;
    assign tag_we        = state == ST_UPDATE && cacheable_r;
    assign touch         = (state == ST_LOOKUP && hit) || tag_we;

    assign arvalid = state == ST_ADDR;
    assign araddr  = cacheable_r ? icache_pkg::line_base(addr_r) : addr_r;
    assign arlen   = cacheable_r ? axi_pkg::len_t'(`ICACHE_BURST_BEATS - 1) : '0;
    assign arburst = cacheable_r ? axi_pkg::INCR : axi_pkg::FIXED;

    a_ar_hold : assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // no read beat may still be arriving when the word goes back
    a_no_ok_during_beat : assert property (@(posedge clk) disable iff (rst)
        data_ok |-> !rvalid);

endmodule

`default_nettype wire

/* logic/icache_data.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_data (
    input  wire                        clk,
    input  wire icache_pkg::addr_t     addr,
    input  wire                        refill_we,
    input  wire icache_pkg::offset_t   refill_offset,
    input  wire icache_pkg::word_t     refill_word,
    input  wire icache_pkg::way_t      victim,
    input  wire icache_pkg::way_mask_t hit_mask,
    output icache_pkg::word_t          hit_word
);

    icache_pkg::offset_t word_sel;
    icache_pkg::word_t   way_word [`ICACHE_WAYS];

    // refill beats steer the word index, lookups use the address
    assign word_sel = refill_we ? refill_offset : icache_pkg::offset_of(addr);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_ram #(
            .entry_t(icache_pkg::word_t),
            .depth(`ICACHE_SETS * `ICACHE_LINE_WORDS)
        ) u_ram (
            .clk(clk),
            .addr({icache_pkg::set_of(addr), word_sel}),
            .we(refill_we && victim == icache_pkg::way_t'(w)),
            .wdata(refill_word),
            .rdata(way_word[w])
        );
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_mask[w]) begin
                hit_word = hit_word | way_word[w];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/icache_pkg.sv */
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    localparam int BYTE_BITS   = $clog2(`ICACHE_WORD_BITS / 8);
    localparam int OFFSET_BITS = $clog2(`ICACHE_LINE_WORDS);
    localparam int SET_BITS    = $clog2(`ICACHE_SETS);
    localparam int TAG_BITS    = `ICACHE_ADDR_BITS - SET_BITS - OFFSET_BITS - BYTE_BITS;

    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`ICACHE_WORD_BITS-1:0] word_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

    function automatic set_t set_of(addr_t a);
        return a[BYTE_BITS+OFFSET_BITS +: SET_BITS];
    endfunction

    function automatic tag_t tag_of(addr_t a);
        return a[`ICACHE_ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic offset_t offset_of(addr_t a);
        return a[BYTE_BITS +: OFFSET_BITS];
    endfunction

    // first byte of the line holding a
    function automatic addr_t line_base(addr_t a);
        return {a[`ICACHE_ADDR_BITS-1:OFFSET_BITS+BYTE_BITS], {(OFFSET_BITS+BYTE_BITS){1'b0}}};
    endfunction

endpackage

`default_nettype wire

/* logic/icache_plru.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_plru (
    input  wire                        clk,
    input  wire                        rst,
    input  wire icache_pkg::set_t      set,
    input  wire                        touch,
    input  wire icache_pkg::way_mask_t hit_mask,
    output icache_pkg::way_t           victim
);

    logic [`ICACHE_SETS-1:0] root;
    logic [`ICACHE_SETS-1:0] leaf0;
    logic [`ICACHE_SETS-1:0] leaf1;
    icache_pkg::way_t        hit_way;
    icache_pkg::way_t        mark;

    // root points away from the recently used half
    always_comb begin
        if (!root[set]) begin
            victim = leaf0[set] ? 2'd1 : 2'd0;
        end else begin
            victim = leaf1[set] ? 2'd3 : 2'd2;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_mask[w]) begin
                hit_way = icache_pkg::way_t'(w);
            end
        end
    end

    // no hit means a refill just finished in the victim
    assign mark = (|hit_mask) ? hit_way : victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            root  <= '0;
            leaf0 <= '0;
            leaf1 <= '0;
        end else if (touch) begin
            root[set] <= ~mark[1];
            if (!mark[1]) begin
                leaf0[set] <= ~mark[0];
            end else begin
                leaf1[set] <= ~mark[0];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/icache_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int depth = 128
) (
    input  wire                     clk,
    input  wire [$clog2(depth)-1:0] addr,
    input  wire                     we,
    input  wire entry_t             wdata,
    output entry_t                  rdata
);

    entry_t mem [depth];

    // read returns the old entry on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* logic/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 128
`define ICACHE_LINE_WORDS 8

// datapath widths
`define ICACHE_WORD_BITS 32
`define ICACHE_ADDR_BITS 32

// one refill burst covers a whole line
`define ICACHE_BURST_BEATS `ICACHE_LINE_WORDS

`endif

/* logic/icache_tags.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_tags (
    input  wire                    clk,
    input  wire                    rst,
    input  wire icache_pkg::addr_t addr,
    input  wire                    tag_we,
    input  wire icache_pkg::way_t  victim,
    output icache_pkg::way_mask_t  hit_mask
);

    icache_pkg::set_t      lookup_set;
    icache_pkg::tag_t      tag_q;
    icache_pkg::way_mask_t valid [`ICACHE_SETS];
    icache_pkg::way_mask_t valid_q;
    icache_pkg::tag_t      stored [`ICACHE_WAYS];

    assign lookup_set = icache_pkg::set_of(addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid[s] <= '0;
            end
            valid_q <= '0;
        end else begin
            if (tag_we) begin
                valid[lookup_set][victim] <= 1'b1;
            end
            valid_q <= valid[lookup_set];
        end
    end

    // lookup tag lines up with the ram output
    always_ff @(posedge clk) begin
        tag_q <= icache_pkg::tag_of(addr);
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_ram #(
            .entry_t(icache_pkg::tag_t),
            .depth(`ICACHE_SETS)
        ) u_ram (
            .clk(clk),
            .addr(lookup_set),
            .we(tag_we && victim == icache_pkg::way_t'(w)),
            .wdata(icache_pkg::tag_of(addr)),
            .rdata(stored[w])
        );
        assign hit_mask[w] = valid_q[w] && stored[w] == tag_q;
    end

    // a line is only refilled after a miss, so a tag never sits in two ways
    a_one_hit : assert property (@(posedge clk) disable iff (rst) $onehot0(hit_mask));

endmodule

`default_nettype wire

/* logic/icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req,
    input  wire icache_pkg::addr_t addr,
    input  wire                    cacheable,
    output wire                    ready,
    output wire                    data_ok,
    output icache_pkg::word_t      rdata,
    output wire                    arvalid,
    input  wire                    arready,
    output icache_pkg::addr_t      araddr,
    output axi_pkg::len_t          arlen,
    output axi_pkg::burst_t        arburst,
    input  wire                    rvalid,
    input  wire icache_pkg::word_t rdata_bus,
    input  wire                    rlast
);

    wire icache_pkg::addr_t     lookup_addr;
    wire icache_pkg::set_t      lookup_set;
    wire icache_pkg::way_mask_t hit_mask;
    wire icache_pkg::word_t     hit_word;
    wire icache_pkg::way_t      victim;
    wire                        refill_we;
    wire icache_pkg::offset_t   refill_offset;
    wire icache_pkg::word_t     refill_word;
    wire                        tag_we;
    wire                        touch;

    assign lookup_set = icache_pkg::set_of(lookup_addr);

    icache_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .req(req),
        .addr(addr),
        .cacheable(cacheable),
        .ready(ready),
        .data_ok(data_ok),
        .rdata(rdata),
        .lookup_addr(lookup_addr),
        .hit_mask(hit_mask),
        .hit_word(hit_word),
        .refill_we(refill_we),
        .refill_offset(refill_offset),
        .refill_word(refill_word),
        .tag_we(tag_we),
        .touch(touch),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .arlen(arlen),
        .arburst(arburst),
        .rvalid(rvalid),
        .rdata_bus(rdata_bus),
        .rlast(rlast)
    );

    icache_tags u_tags (
        .clk(clk),
        .rst(rst),
        .addr(lookup_addr),
        .tag_we(tag_we),
        .victim(victim),
        .hit_mask(hit_mask)
    );

    icache_data u_data (
        .clk(clk),
        .addr(lookup_addr),
        .refill_we(refill_we),
        .refill_offset(refill_offset),
        .refill_word(refill_word),
        .victim(victim),
        .hit_mask(hit_mask),
        .hit_word(hit_word)
    );

    icache_plru u_plru (
        .clk(clk),
        .rst(rst),
        .set(lookup_set),
        .touch(touch),
        .hit_mask(hit_mask),
        .victim(victim)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f compile.f -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
